/* design/sys_settings.svh */
// System address map
`ifndef SYS_SETTINGS_SVH
`define SYS_SETTINGS_SVH

// RAM region, 16 KB
`define RAM_BASE (32'h0010_0000)
`define RAM_MASK (32'hFFFF_C000)

// Machine timer, 1 KB
`define TIMER_BASE (32'h0003_0000)
`define TIMER_MASK (32'hFFFF_FC00)

// Copy engine registers, 1 KB
`define COPY_BASE (32'h0004_0000)
`define COPY_MASK (32'hFFFF_FC00)

// RAM depth in 32-bit words
`define RAM_WORDS 4096

`endif

/* design/sys_pkg.sv */
// System bus package
`default_nettype none

package sys_pkg;

  localparam int NR_HOSTS   = 2;
  localparam int NR_DEVICES = 3;

  typedef enum logic [0:0] {
    CoreD    = 1'b0,
    CopyHost = 1'b1
  } bus_host_e;

  typedef enum logic [1:0] {
    Ram,
    Timer,
    CopyCfg
  } bus_device_e;

  // Timer register offsets
  localparam logic [31:0] TMR_MTIME_LO = 32'h0;
  localparam logic [31:0] TMR_MTIME_HI = 32'h4;
  localparam logic [31:0] TMR_CMP_LO   = 32'h8;
  localparam logic [31:0] TMR_CMP_HI   = 32'hC;

  // Copy engine register offsets
  localparam logic [31:0] COPY_SRC  = 32'h0;
  localparam logic [31:0] COPY_DST  = 32'h4;
  localparam logic [31:0] COPY_LEN  = 32'h8;
  localparam logic [31:0] COPY_CTRL = 32'hC;

endpackage

`default_nettype wire

/* design/bus_if.sv */
// Request/grant bus port
`default_nettype none

interface bus_if;

  logic        req;
  logic        gnt;
  logic [31:0] addr;
  logic        we;
  logic [3:0]  be;
  logic [31:0] wdata;
  logic        rvalid;
  logic [31:0] rdata;
  logic        err;

  // Requesting side
  modport host (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  // Answering side, devices always accept so gnt follows req
  modport device (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

`default_nettype wire

/* design/sys_bus.sv */
// Shared request/grant bus
`default_nettype none
`include "sys_settings.svh"

module sys_bus (
  input  logic  clk_i,
  input  logic  rst_n_i,
  bus_if.device host_port [sys_pkg::NR_HOSTS],
  bus_if.host   dev_port  [sys_pkg::NR_DEVICES]
);

  logic [31:0] dev_base [sys_pkg::NR_DEVICES];
  logic [31:0] dev_mask [sys_pkg::NR_DEVICES];

  // Host side, flattened
  logic                 host_req    [sys_pkg::NR_HOSTS];
  logic                 host_gnt    [sys_pkg::NR_HOSTS];
  logic [31:0]          host_addr   [sys_pkg::NR_HOSTS];
  logic                 host_we     [sys_pkg::NR_HOSTS];
  logic [3:0]           host_be     [sys_pkg::NR_HOSTS];
  logic [31:0]          host_wdata  [sys_pkg::NR_HOSTS];
  logic                 host_rvalid [sys_pkg::NR_HOSTS];
  logic [31:0]          host_rdata  [sys_pkg::NR_HOSTS];
  logic                 host_err    [sys_pkg::NR_HOSTS];
  logic                 host_miss   [sys_pkg::NR_HOSTS];
  logic                 host_win    [sys_pkg::NR_HOSTS];
  sys_pkg::bus_device_e host_dev    [sys_pkg::NR_HOSTS];

  // Device side
  logic                 dev_req    [sys_pkg::NR_DEVICES];
  logic                 dev_gnt    [sys_pkg::NR_DEVICES];
  logic                 dev_rvalid [sys_pkg::NR_DEVICES];
  logic [31:0]          dev_rdata  [sys_pkg::NR_DEVICES];
  logic                 dev_err    [sys_pkg::NR_DEVICES];
  sys_pkg::bus_host_e   dev_owner  [sys_pkg::NR_DEVICES];

  // Outstanding response per host
  logic                 pend_q     [sys_pkg::NR_HOSTS];
  logic                 pend_err_q [sys_pkg::NR_HOSTS];
  sys_pkg::bus_device_e pend_dev_q [sys_pkg::NR_HOSTS];

  assign dev_base[sys_pkg::Ram]     = `RAM_BASE;
  assign dev_mask[sys_pkg::Ram]     = `RAM_MASK;
  assign dev_base[sys_pkg::Timer]   = `TIMER_BASE;
  assign dev_mask[sys_pkg::Timer]   = `TIMER_MASK;
  assign dev_base[sys_pkg::CopyCfg] = `COPY_BASE;
  assign dev_mask[sys_pkg::CopyCfg] = `COPY_MASK;

  for (genvar h = 0; h < sys_pkg::NR_HOSTS; h++) begin : g_host
    assign host_req[h]   = host_port[h].req;
    assign host_addr[h]  = host_port[h].addr;
    assign host_we[h]    = host_port[h].we;
    assign host_be[h]    = host_port[h].be;
    assign host_wdata[h] = host_port[h].wdata;

    // Unmapped addresses are granted and answered locally
    assign host_gnt[h] = host_req[h] &
                         (host_miss[h] | (host_win[h] & dev_gnt[host_dev[h]]));

    assign host_port[h].gnt    = host_gnt[h];
    assign host_port[h].rvalid = host_rvalid[h];
    assign host_port[h].rdata  = host_rdata[h];
    assign host_port[h].err    = host_err[h];
  end

  for (genvar d = 0; d < sys_pkg::NR_DEVICES; d++) begin : g_dev
    assign dev_port[d].req   = dev_req[d];
    assign dev_port[d].addr  = host_addr[dev_owner[d]];
    assign dev_port[d].we    = host_we[dev_owner[d]];
    assign dev_port[d].be    = host_be[dev_owner[d]];
    assign dev_port[d].wdata = host_wdata[dev_owner[d]];

    assign dev_gnt[d]    = dev_port[d].gnt;
    assign dev_rvalid[d] = dev_port[d].rvalid;
    assign dev_rdata[d]  = dev_port[d].rdata;
    assign dev_err[d]    = dev_port[d].err;
  end

  // Address decode
  always_comb begin
    for (int h = 0; h < sys_pkg::NR_HOSTS; h++) begin
      host_miss[h] = 1'b1;
      host_dev[h]  = sys_pkg::Ram;
      for (int d = 0; d < sys_pkg::NR_DEVICES; d++) begin
        if ((host_addr[h] & dev_mask[d]) == dev_base[d]) begin
          host_miss[h] = 1'b0;
          host_dev[h]  = sys_pkg::bus_device_e'(d);
        end
      end
    end
  end

  // Fixed priority, lower host index first
  always_comb begin
    for (int d = 0; d < sys_pkg::NR_DEVICES; d++) begin
      dev_req[d]   = 1'b0;
      dev_owner[d] = sys_pkg::CoreD;
    end
    for (int h = 0; h < sys_pkg::NR_HOSTS; h++) begin
      host_win[h] = 1'b0;
      if (host_req[h] && !host_miss[h] && !dev_req[host_dev[h]]) begin
        dev_req[host_dev[h]]   = 1'b1;
        dev_owner[host_dev[h]] = sys_pkg::bus_host_e'(h);
        host_win[h]            = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int h = 0; h < sys_pkg::NR_HOSTS; h++) begin
        pend_q[h]     <= 1'b0;
        pend_err_q[h] <= 1'b0;
        pend_dev_q[h] <= sys_pkg::Ram;
      end
    end else begin
      for (int h = 0; h < sys_pkg::NR_HOSTS; h++) begin
        if (host_gnt[h]) begin
          pend_q[h]     <= 1'b1;
          pend_err_q[h] <= host_miss[h];
          pend_dev_q[h] <= host_dev[h];
        end else if (host_rvalid[h]) begin
          pend_q[h] <= 1'b0;
        end
      end
    end
  end

  // Response routing from the recorded source
  always_comb begin
    for (int h = 0; h < sys_pkg::NR_HOSTS; h++) begin
      host_rvalid[h] = pend_q[h] & (pend_err_q[h] | dev_rvalid[pend_dev_q[h]]);
      host_rdata[h]  = pend_err_q[h] ? 32'd0 : dev_rdata[pend_dev_q[h]];
      host_err[h]    = pend_q[h] & (pend_err_q[h] | dev_err[pend_dev_q[h]]);
    end
  end

endmodule

`default_nettype wire

/* design/sys_ram.sv */
// Byte-enabled word RAM
`default_nettype none
`include "sys_settings.svh"

module sys_ram (
  input  logic  clk_i,
  input  logic  rst_n_i,
  bus_if.device bus
);

  localparam int idx_w = $clog2(`RAM_WORDS);

  logic [31:0]      mem [`RAM_WORDS];
  logic [31:0]      offset;
  logic [idx_w-1:0] word_idx;
  logic             rvalid_q;
  logic [31:0]      rdata_q;

  assign offset   = bus.addr & ~`RAM_MASK;
  assign word_idx = offset[idx_w+1:2];

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus.be[b]) begin
            mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end
      rdata_q <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

`default_nettype wire

/* design/sys_timer.sv */
// Machine timer
`default_nettype none
`include "sys_settings.svh"

module sys_timer (
  input  logic  clk_i,
  input  logic  rst_n_i,
  bus_if.device bus,
  output logic  timer_irq_o
);

  logic [63:0] mtime_q;
  logic [63:0] cmp_q;
  logic [31:0] offset;
  logic        known;
  logic        bad;
  logic        wr;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  assign offset = bus.addr & ~`TIMER_MASK;
  assign known  = offset inside {sys_pkg::TMR_MTIME_LO, sys_pkg::TMR_MTIME_HI,
                                 sys_pkg::TMR_CMP_LO, sys_pkg::TMR_CMP_HI};
  // Only full-word writes are legal
  assign bad    = ~known | (bus.we & (bus.be != 4'hF));
  assign wr     = bus.req & bus.we & ~bad;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q <= '0;
      cmp_q   <= '1;
    end else begin
      mtime_q <= mtime_q + 64'd1;
      if (wr) begin
        case (offset)
          sys_pkg::TMR_MTIME_LO: mtime_q[31:0]  <= bus.wdata;
          sys_pkg::TMR_MTIME_HI: mtime_q[63:32] <= bus.wdata;
          sys_pkg::TMR_CMP_LO:   cmp_q[31:0]    <= bus.wdata;
          sys_pkg::TMR_CMP_HI:   cmp_q[63:32]   <= bus.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req & bad;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= '0;
    if (bus.req && !bus.we && !bad) begin
      case (offset)
        sys_pkg::TMR_MTIME_LO: rdata_q <= mtime_q[31:0];
        sys_pkg::TMR_MTIME_HI: rdata_q <= mtime_q[63:32];
        sys_pkg::TMR_CMP_LO:   rdata_q <= cmp_q[31:0];
        sys_pkg::TMR_CMP_HI:   rdata_q <= cmp_q[63:32];
        default: ;
      endcase
    end
  end

  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;

  assign timer_irq_o = (mtime_q >= cmp_q);

endmodule

`default_nettype wire

/* design/copy_engine.sv */
// Word copy engine
`default_nettype none
`include "sys_settings.svh"

module copy_engine (
  input  logic  clk_i,
  input  logic  rst_n_i,
  bus_if.device cfg,
  bus_if.host   mem,
  output logic  copy_done_irq_o
);

  typedef enum logic [2:0] {
    Idle,
    RdReq,
    RdWait,
    WrReq,
    WrWait
  } state_e;

  state_e      state_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [31:0] len_q;
  logic [31:0] idx_q;
  logic [31:0] data_q;
  logic [31:0] word_off;
  logic        done_q;
  logic        fault_q;
  logic        busy;

  // Register port decode
  logic [31:0] offset;
  logic        known;
  logic        bad;
  logic        cfg_wr;
  logic        ctrl_wr;
  logic        cfg_rvalid_q;
  logic        cfg_err_q;
  logic [31:0] cfg_rdata_q;

  assign busy     = (state_q != Idle);
  assign word_off = {idx_q[29:0], 2'b00};

  assign offset  = cfg.addr & ~`COPY_MASK;
  assign known   = offset inside {sys_pkg::COPY_SRC, sys_pkg::COPY_DST,
                                  sys_pkg::COPY_LEN, sys_pkg::COPY_CTRL};
  assign bad     = ~known | (cfg.we & (cfg.be != 4'hF));
  // Writes while busy are acknowledged but dropped
  assign cfg_wr  = cfg.req & cfg.we & ~bad & ~busy;
  assign ctrl_wr = cfg_wr & (offset == sys_pkg::COPY_CTRL);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (cfg_wr) begin
      case (offset)
        sys_pkg::COPY_SRC: src_q <= cfg.wdata;
        sys_pkg::COPY_DST: dst_q <= cfg.wdata;
        sys_pkg::COPY_LEN: len_q <= cfg.wdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_rvalid_q <= 1'b0;
      cfg_err_q    <= 1'b0;
    end else begin
      cfg_rvalid_q <= cfg.req;
      cfg_err_q    <= cfg.req & bad;
    end
  end

  always_ff @(posedge clk_i) begin
    cfg_rdata_q <= '0;
    if (cfg.req && !cfg.we && !bad) begin
      case (offset)
        sys_pkg::COPY_SRC:  cfg_rdata_q <= src_q;
        sys_pkg::COPY_DST:  cfg_rdata_q <= dst_q;
        sys_pkg::COPY_LEN:  cfg_rdata_q <= len_q;
        sys_pkg::COPY_CTRL: cfg_rdata_q <= {29'd0, fault_q, done_q, busy};
        default: ;
      endcase
    end
  end

  // One word per pass: read, wait, write, wait
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
      idx_q   <= '0;
      done_q  <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      case (state_q)
        Idle: begin
          if (ctrl_wr) begin
            done_q  <= 1'b0;
            fault_q <= 1'b0;
            if (cfg.wdata[0]) begin
              idx_q <= '0;
              if (len_q == '0) begin
                done_q <= 1'b1;
              end else begin
                state_q <= RdReq;
              end
            end
          end
        end
        RdReq: begin
          if (mem.gnt) begin
            state_q <= RdWait;
          end
        end
        RdWait: begin
          if (mem.rvalid) begin
            if (mem.err) begin
              fault_q <= 1'b1;
              state_q <= Idle;
            end else begin
              state_q <= WrReq;
            end
          end
        end
        WrReq: begin
          if (mem.gnt) begin
            state_q <= WrWait;
          end
        end
        WrWait: begin
          if (mem.rvalid) begin
            if (mem.err) begin
              fault_q <= 1'b1;
              state_q <= Idle;
            end else if (idx_q == len_q - 32'd1) begin
              done_q  <= 1'b1;
              state_q <= Idle;
            end else begin
              idx_q   <= idx_q + 32'd1;
              state_q <= RdReq;
            end
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Word in flight between read and write
  always_ff @(posedge clk_i) begin
    if (state_q == RdWait && mem.rvalid) begin
      data_q <= mem.rdata;
    end
  end

  assign mem.req   = (state_q == RdReq) || (state_q == WrReq);
  assign mem.we    = (state_q == WrReq);
  assign mem.addr  = ((state_q == WrReq) ? dst_q : src_q) + word_off;
  assign mem.be    = 4'hF;
  assign mem.wdata = data_q;

  assign cfg.gnt    = cfg.req;
  assign cfg.rvalid = cfg_rvalid_q;
  assign cfg.rdata  = cfg_rdata_q;
  assign cfg.err    = cfg_err_q;

  assign copy_done_irq_o = done_q | fault_q;

endmodule

`default_nettype wire

/* design/simple_system.sv */
// Simple bus system top level
`default_nettype none

module simple_system (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        host_req_i,
  input  logic [31:0] host_addr_i,
  input  logic        host_we_i,
  input  logic [3:0]  host_be_i,
  input  logic [31:0] host_wdata_i,
  output logic        host_gnt_o,
  output logic        host_rvalid_o,
  output logic [31:0] host_rdata_o,
  output logic        host_err_o,
  output logic        timer_irq_o,
  output logic        copy_done_irq_o
);

  bus_if host_bus [sys_pkg::NR_HOSTS] ();
  bus_if dev_bus  [sys_pkg::NR_DEVICES] ();

  // External port stands in for the core data side
  assign host_bus[sys_pkg::CoreD].req   = host_req_i;
  assign host_bus[sys_pkg::CoreD].addr  = host_addr_i;
  assign host_bus[sys_pkg::CoreD].we    = host_we_i;
  assign host_bus[sys_pkg::CoreD].be    = host_be_i;
  assign host_bus[sys_pkg::CoreD].wdata = host_wdata_i;

  assign host_gnt_o    = host_bus[sys_pkg::CoreD].gnt;
  assign host_rvalid_o = host_bus[sys_pkg::CoreD].rvalid;
  assign host_rdata_o  = host_bus[sys_pkg::CoreD].rdata;
  assign host_err_o    = host_bus[sys_pkg::CoreD].err;

  sys_bus u_bus (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .host_port (host_bus),
    .dev_port  (dev_bus)
  );

  sys_ram u_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (dev_bus[sys_pkg::Ram])
  );

  sys_timer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus         (dev_bus[sys_pkg::Timer]),
    .timer_irq_o (timer_irq_o)
  );

  // Copy engine is both a device and the second host
  copy_engine u_copy (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg             (dev_bus[sys_pkg::CopyCfg]),
    .mem             (host_bus[sys_pkg::CopyHost]),
    .copy_done_irq_o (copy_done_irq_o)
  );

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
// Testbench clock and reset
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  // Period of 4
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held for eight cycles, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/sys_bus_checker.sv */
// Bus handshake assertions
`default_nettype none

module sys_bus_checker (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic [sys_pkg::NR_HOSTS-1:0] req_i,
  input logic [sys_pkg::NR_HOSTS-1:0] gnt_i,
  input logic [sys_pkg::NR_HOSTS-1:0] rvalid_i
);

  for (genvar h = 0; h < sys_pkg::NR_HOSTS; h++) begin : g_host
    // Grant only for a live request
    gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      gnt_i[h] |-> req_i[h])
      else $error("host %0d granted without a request", h);

    // Response exactly one cycle after the grant
    rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      gnt_i[h] |=> rvalid_i[h])
      else $error("host %0d got no response one cycle after its grant", h);

    rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid_i[h] |-> $past(gnt_i[h]))
      else $error("host %0d got a response without a grant", h);

    // Back-to-back grant only as the earlier response arrives
    one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (gnt_i[h] && $past(gnt_i[h])) |-> rvalid_i[h])
      else $error("host %0d granted twice with a response pending", h);
  end

endmodule

bind sys_bus sys_bus_checker u_bus_checker (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .req_i    ({host_req[1], host_req[0]}),
  .gnt_i    ({host_gnt[1], host_gnt[0]}),
  .rvalid_i ({host_rvalid[1], host_rvalid[0]})
);

`default_nettype wire

/* verif/tb_simple_system.sv */
// Simple system testbench
`default_nettype none
`include "sys_settings.svh"

module tb_simple_system;

  localparam int          WAIT_LIMIT    = 2000;
  localparam logic [31:0] UNMAPPED_ADDR = 32'h0200_0000;
  localparam logic [31:0] MTIME_LO_REG  = `TIMER_BASE + sys_pkg::TMR_MTIME_LO;
  localparam logic [31:0] MTIME_HI_REG  = `TIMER_BASE + sys_pkg::TMR_MTIME_HI;
  localparam logic [31:0] CMP_LO_REG    = `TIMER_BASE + sys_pkg::TMR_CMP_LO;
  localparam logic [31:0] CMP_HI_REG    = `TIMER_BASE + sys_pkg::TMR_CMP_HI;
  localparam logic [31:0] SRC_REG       = `COPY_BASE + sys_pkg::COPY_SRC;
  localparam logic [31:0] DST_REG       = `COPY_BASE + sys_pkg::COPY_DST;
  localparam logic [31:0] LEN_REG       = `COPY_BASE + sys_pkg::COPY_LEN;
  localparam logic [31:0] CTRL_REG      = `COPY_BASE + sys_pkg::COPY_CTRL;

  logic        clk;
  logic        rst_n;
  logic        host_req;
  logic [31:0] host_addr;
  logic        host_we;
  logic [3:0]  host_be;
  logic [31:0] host_wdata;
  logic        host_gnt;
  logic        host_rvalid;
  logic [31:0] host_rdata;
  logic        host_err;
  logic        timer_irq;
  logic        copy_done_irq;

  logic [31:0] rng_state;
  logic [31:0] ram_model [int];
  int          checks_run;
  int          errors;
  int          test_errors;
  logic        aborted;

  tb_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  simple_system DUT (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .host_req_i      (host_req),
    .host_addr_i     (host_addr),
    .host_we_i       (host_we),
    .host_be_i       (host_be),
    .host_wdata_i    (host_wdata),
    .host_gnt_o      (host_gnt),
    .host_rvalid_o   (host_rvalid),
    .host_rdata_o    (host_rdata),
    .host_err_o      (host_err),
    .timer_irq_o     (timer_irq),
    .copy_done_irq_o (copy_done_irq)
  );

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    // Upper LCG bits are the better ones
    return {rng_state[15:0], rng_state[31:16]};
  endfunction

  function automatic logic [31:0] ram_addr(input int idx);
    return `RAM_BASE + 32'(idx) * 32'd4;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks_run++;
    if (!aborted && got !== expected) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, expected);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    aborted = 1'b1;
    $display("ERROR: timed out waiting for %s", what);
  endtask

  task automatic finish_test(input string name);
    if (!aborted) $display("%s: %0d mismatches", name, test_errors);
    test_errors = 0;
  endtask

  // One access on the external host port
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    rdata = 32'd0;
    err   = 1'b0;
    if (aborted) return;
    @(negedge clk);
    host_req   = 1'b1;
    host_addr  = addr;
    host_we    = we;
    host_be    = be;
    host_wdata = wdata;
    waited = 0;
    @(posedge clk);
    while (!host_gnt && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (!host_gnt) begin
      report_timeout("a bus grant");
      return;
    end
    // Core has top priority, so its grant comes at once
    check_value("host_gnt_o wait cycles", 32'(waited), 32'd0);
    @(negedge clk);
    host_req = 1'b0;
    host_we  = 1'b0;
    // Response is due one cycle after the grant
    waited = 1;
    @(posedge clk);
    while (!host_rvalid && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (!host_rvalid) begin
      report_timeout("a bus response");
      return;
    end
    check_value("host_rvalid_o latency", 32'(waited), 32'd1);
    rdata = host_rdata;
    err   = host_err;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] value);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, addr, 4'hF, value, rdata, err);
    check_value($sformatf("host_err_o @%08h", addr), 32'(err), 32'd0);
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] value);
    logic err;
    bus_access(1'b0, addr, 4'h0, 32'd0, value, err);
    check_value($sformatf("host_err_o @%08h", addr), 32'(err), 32'd0);
  endtask

  task automatic ram_write(input int idx, input logic [31:0] data, input logic [3:0] be);
    logic [31:0] old_word;
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, ram_addr(idx), be, data, rdata, err);
    check_value("host_err_o", 32'(err), 32'd0);
    old_word = ram_model.exists(idx) ? ram_model[idx] : 32'd0;
    ram_model[idx] = merge_bytes(old_word, data, be);
  endtask

  task automatic ram_check(input int idx);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b0, ram_addr(idx), 4'h0, 32'd0, rdata, err);
    check_value($sformatf("host_rdata_o @%08h", ram_addr(idx)), rdata, ram_model[idx]);
    check_value("host_err_o", 32'(err), 32'd0);
  endtask

  task automatic wait_irq(input logic copy_sel);
    int waited;
    waited = 0;
    if (aborted) return;
    @(posedge clk);
    while (!(copy_sel ? copy_done_irq : timer_irq) && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (!(copy_sel ? copy_done_irq : timer_irq))
      report_timeout(copy_sel ? "copy_done_irq_o" : "timer_irq_o");
  endtask

  task automatic start_copy(input logic [31:0] src, input logic [31:0] dst,
                            input logic [31:0] len);
    reg_write(SRC_REG, src);
    reg_write(DST_REG, dst);
    reg_write(LEN_REG, len);
    reg_write(CTRL_REG, 32'h1);
  endtask

  task automatic test_ram();
    logic [31:0] r;
    for (int i = 0; i < 32; i++) ram_write(i, next_random(), 4'hF);
    for (int n = 0; n < 48; n++) begin
      r = next_random();
      ram_write(int'(r[20:16]), next_random(), r[3:0]);
    end
    for (int i = 0; i < 32; i++) ram_check(i);
    finish_test("ram byte enables");
  endtask

  task automatic test_errors_path();
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b0, UNMAPPED_ADDR, 4'h0, 32'd0, rdata, err);
    check_value("host_err_o", 32'(err), 32'd1);
    check_value("host_rdata_o", rdata, 32'd0);
    bus_access(1'b1, `TIMER_BASE + 32'h10, 4'hF, 32'd5, rdata, err);
    check_value("host_err_o", 32'(err), 32'd1);
    // Half-word write to the compare register is refused
    bus_access(1'b1, CMP_LO_REG, 4'h3, 32'h1234_5678, rdata, err);
    check_value("host_err_o", 32'(err), 32'd1);
    reg_read(CMP_LO_REG, rdata);
    check_value("cmp_lo", rdata, 32'hFFFF_FFFF);
    finish_test("error responses");
  endtask

  task automatic test_timer();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] target;
    reg_read(MTIME_LO_REG, lo);
    reg_read(MTIME_HI_REG, hi);
    target = lo + 32'd40;
    reg_write(CMP_LO_REG, target);
    reg_write(CMP_HI_REG, hi);
    check_value("timer_irq_o", 32'(timer_irq), 32'd0);
    wait_irq(1'b0);
    reg_read(MTIME_LO_REG, lo);
    check_value("mtime at or past compare", 32'(lo >= target), 32'd1);
    reg_write(CMP_HI_REG, 32'hFFFF_FFFF);
    reg_write(CMP_LO_REG, 32'hFFFF_FFFF);
    check_value("timer_irq_o", 32'(timer_irq), 32'd0);
    finish_test("timer interrupt");
  endtask

  task automatic test_copy();
    logic [31:0] len;
    logic [31:0] ctrl;
    len = 32'd1 + next_random() % 32'd32;
    for (int i = 0; i < 32; i++) ram_write(256 + i, next_random(), 4'hF);
    start_copy(ram_addr(256), ram_addr(512), len);
    wait_irq(1'b1);
    reg_read(CTRL_REG, ctrl);
    check_value("copy ctrl", ctrl, 32'h2);
    for (int i = 0; i < int'(len); i++) ram_model[512 + i] = ram_model[256 + i];
    for (int i = 0; i < int'(len); i++) ram_check(512 + i);
    reg_write(CTRL_REG, 32'h0);
    check_value("copy_done_irq_o", 32'(copy_done_irq), 32'd0);
    finish_test("word copy");
  endtask

  task automatic test_arbitration();
    logic [31:0] r;
    logic [31:0] value;
    int          idx;
    for (int i = 0; i < 32; i++) ram_write(768 + i, next_random(), 4'hF);
    start_copy(ram_addr(768), ram_addr(1024), 32'd32);
    reg_read(CTRL_REG, value);
    check_value("copy ctrl", value, 32'h1);
    // Busy engine keeps its old source
    reg_write(SRC_REG, ram_addr(2000));
    reg_read(SRC_REG, value);
    check_value("copy src", value, ram_addr(768));
    for (int n = 0; n < 24; n++) begin
      r = next_random();
      idx = 1536 + int'(r[19:16]);
      if (!ram_model.exists(idx))
        ram_write(idx, next_random(), 4'hF);
      else if (r[8])
        ram_write(idx, next_random(), r[3:0]);
      else
        ram_check(idx);
    end
    wait_irq(1'b1);
    reg_read(CTRL_REG, value);
    check_value("copy ctrl", value, 32'h2);
    for (int i = 0; i < 32; i++) ram_model[1024 + i] = ram_model[768 + i];
    for (int i = 0; i < 32; i++) ram_check(1024 + i);
    reg_write(CTRL_REG, 32'h0);
    finish_test("arbitration");
  endtask

  task automatic test_copy_corners();
    logic [31:0] ctrl;
    start_copy(ram_addr(256), ram_addr(1800), 32'd0);
    wait_irq(1'b1);
    reg_read(CTRL_REG, ctrl);
    check_value("copy ctrl", ctrl, 32'h2);
    reg_write(CTRL_REG, 32'h0);
    start_copy(UNMAPPED_ADDR, ram_addr(1800), 32'd4);
    wait_irq(1'b1);
    reg_read(CTRL_REG, ctrl);
    check_value("copy ctrl", ctrl, 32'h4);
    check_value("copy_done_irq_o", 32'(copy_done_irq), 32'd1);
    reg_write(CTRL_REG, 32'h0);
    check_value("copy_done_irq_o", 32'(copy_done_irq), 32'd0);
    finish_test("copy corner cases");
  endtask

  initial begin
    int waited;
    host_req    = 1'b0;
    host_addr   = 32'd0;
    host_we     = 1'b0;
    host_be     = 4'h0;
    host_wdata  = 32'd0;
    rng_state   = 32'd82;
    checks_run  = 0;
    errors      = 0;
    test_errors = 0;
    aborted     = 1'b0;
    waited = 0;
    while (rst_n !== 1'b1 && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) report_timeout("reset release");
    check_value("timer_irq_o", 32'(timer_irq), 32'd0);
    check_value("copy_done_irq_o", 32'(copy_done_irq), 32'd0);
    check_value("host_rvalid_o", 32'(host_rvalid), 32'd0);
    check_value("host_err_o", 32'(host_err), 32'd0);
    test_ram();
    test_errors_path();
    test_timer();
    test_copy();
    test_arbitration();
    test_copy_corners();
    $display("checks: %0d, mismatches: %0d", checks_run, errors);
    if (errors == 0 && !aborted) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+design
design/sys_pkg.sv
design/bus_if.sv
design/sys_bus.sv
design/sys_ram.sv
design/sys_timer.sv
design/copy_engine.sv
design/simple_system.sv
verif/tb_clkgen.sv
verif/sys_bus_checker.sv
verif/tb_simple_system.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the simple system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Mdir obj_dir \
  --top-module tb_simple_system -f flist.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1
